// ==== hw/apu_reg_pkg.sv ====
`default_nettype none

package apu_reg_pkg;

	localparam logic [7:0] ADDR_NR21 = 8'h16; // duty, length
	localparam logic [7:0] ADDR_NR22 = 8'h17; // envelope
	localparam logic [7:0] ADDR_NR23 = 8'h18; // freq low
	localparam logic [7:0] ADDR_NR24 = 8'h19; // trigger, length_en, freq high

	typedef struct packed {
		logic [1:0] duty;
		logic [5:0] length_init;
	} ch2_duty_len_t;

	typedef struct packed {
		logic [3:0] init_vol;
		logic       env_up;
		logic [2:0] env_period;
	} ch2_env_t;

	typedef struct packed {
		logic [10:0] freq;
		logic        length_en;
		logic        spare; // always 0
	} ch2_freq_t;

	typedef struct packed {
		ch2_duty_len_t duty_len;
		ch2_env_t      env;
		ch2_freq_t     freq;
	} ch2_regs_t;

	typedef struct packed {
		logic trigger;
		logic length_load;
		logic dac_off_write;
	} ch2_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/apu_timing_pkg.sv ====
`default_nettype none

package apu_timing_pkg;

	typedef struct packed {
		logic len_tick; // 256 Hz
		logic env_tick; // 64 Hz
	} fs_tick_t;

	// steps per frame sequencer cycle
	localparam int FS_STEPS = 8;

	// full length count
	localparam int LEN_MAX = 64;

	// T-cycles per freq timer count
	localparam int TIMER_SCALE = 4;

endpackage

`default_nettype wire

// ==== hw/apu_ch2_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_ch2_regs (
	input  logic                   amuk_4mhz,
	input  logic                   rst_n,
	input  logic                   wr_en,
	input  logic [7:0]             wr_addr,
	input  logic [7:0]             wr_data,
	output apu_reg_pkg::ch2_regs_t regs,
	output apu_reg_pkg::ch2_ctrl_t ctrl
);
	import apu_reg_pkg::*;

	logic sel_nr21;
	logic sel_nr22;
	logic sel_nr23;
	logic sel_nr24;
	logic dac_off;

	assign sel_nr21 = wr_en && (wr_addr == ADDR_NR21);
	assign sel_nr22 = wr_en && (wr_addr == ADDR_NR22);
	assign sel_nr23 = wr_en && (wr_addr == ADDR_NR23);
	assign sel_nr24 = wr_en && (wr_addr == ADDR_NR24);

	assign dac_off = (wr_data[7:3] == 5'd0); // no volume and no env_up

	// register images
	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			if (sel_nr21) begin
				regs.duty_len <= ch2_duty_len_t'(wr_data);
			end
			if (sel_nr22) begin
				regs.env <= ch2_env_t'(wr_data);
			end
			if (sel_nr23) begin
				regs.freq.freq[7:0] <= wr_data;
			end
			if (sel_nr24) begin
				regs.freq.freq[10:8] <= wr_data[2:0];
				regs.freq.length_en  <= wr_data[6];
			end
		end
	end

	// one-cycle control strobes
	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else begin
			ctrl.trigger       <= sel_nr24 && wr_data[7]; // bit 7 not stored
			ctrl.length_load   <= sel_nr21;
			ctrl.dac_off_write <= sel_nr22 && dac_off;
		end
	end

endmodule

`default_nettype wire

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
	parameter int FS_DIV = 8192
) (
	input  logic                     amuk_4mhz,
	input  logic                     rst_n,
	output apu_timing_pkg::fs_tick_t ticks
);
	import apu_timing_pkg::*;

	localparam int DIV_W  = (FS_DIV > 1) ? $clog2(FS_DIV) : 1;
	localparam int STEP_W = $clog2(FS_STEPS);

	logic [DIV_W-1:0]  div_cnt;
	logic [STEP_W-1:0] step;
	logic              div_wrap;
	logic              last_step;

	assign div_wrap  = (div_cnt == DIV_W'(FS_DIV - 1)); // 512 Hz edge
	assign last_step = (step == STEP_W'(FS_STEPS - 1));

	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (div_wrap) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			step  <= '0;
			ticks <= '0;
		end else begin
			ticks.len_tick <= div_wrap && !step[0]; // steps 0, 2, 4, 6
			ticks.env_tick <= div_wrap && last_step;
			if (div_wrap) begin
				step <= last_step ? '0 : step + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/pulse_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_channel (
	input  logic                     amuk_4mhz,
	input  logic                     rst_n,
	input  apu_reg_pkg::ch2_regs_t   regs,
	input  apu_reg_pkg::ch2_ctrl_t   ctrl,
	input  apu_timing_pkg::fs_tick_t ticks,
	output logic [3:0]               ch2_out,
	output logic                     ch2_active,
	output logic                     dac_en
);
	import apu_timing_pkg::*;

	localparam int LEN_W = $clog2(LEN_MAX + 1); // must hold LEN_MAX itself

	logic [11:0]      timer_steps;
	logic [12:0]      timer_reload;
	logic [12:0]      freq_timer;
	logic [2:0]       duty_pos;
	logic [7:0]       duty_pattern;
	logic             wave_hi;
	logic [LEN_W-1:0] len_cnt;
	logic             len_dec;
	logic             len_expire;
	logic [2:0]       env_div;
	logic             env_run;
	logic             env_div_done;
	logic [3:0]       volume;
	logic             active;

	// period in T-cycles, timer runs reload..0
	assign timer_steps  = 12'd2048 - {1'b0, regs.freq.freq};
	assign timer_reload = 13'(timer_steps * TIMER_SCALE - 1);

	always_comb begin
		case (regs.duty_len.duty)
			2'd0:    duty_pattern = 8'b1000_0000; // 12.5%
			2'd1:    duty_pattern = 8'b1000_0001; // 25%
			2'd2:    duty_pattern = 8'b1110_0001; // 50%
			default: duty_pattern = 8'b0111_1110; // 75%
		endcase
	end

	assign wave_hi = duty_pattern[duty_pos];

	assign dac_en = (regs.env.init_vol != 4'd0) || regs.env.env_up;

	// frequency timer and duty position
	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			freq_timer <= '0;
			duty_pos   <= '0;
		end else if (ctrl.trigger) begin
			freq_timer <= timer_reload;
			duty_pos   <= '0;
		end else if (freq_timer == '0) begin
			freq_timer <= timer_reload;
			duty_pos   <= duty_pos + 3'd1;
		end else begin
			freq_timer <= freq_timer - 13'd1;
		end
	end

	// length counter, counts remaining ticks
	assign len_dec    = ticks.len_tick && regs.freq.length_en && (len_cnt != '0);
	assign len_expire = len_dec && (len_cnt == LEN_W'(1));

	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt <= '0;
		end else if (ctrl.trigger) begin
			if (len_cnt == '0) begin
				len_cnt <= LEN_W'(LEN_MAX);
			end
		end else if (ctrl.length_load) begin
			len_cnt <= LEN_W'(LEN_MAX) - LEN_W'(regs.duty_len.length_init);
		end else if (len_dec) begin
			len_cnt <= len_cnt - 1'b1;
		end
	end

	// volume envelope
	assign env_run      = ticks.env_tick && (regs.env.env_period != 3'd0);
	assign env_div_done = (env_div <= 3'd1); // also covers period raised from 0

	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			env_div <= '0;
			volume  <= '0;
		end else if (ctrl.trigger) begin
			env_div <= regs.env.env_period;
			volume  <= regs.env.init_vol;
		end else if (env_run) begin
			if (env_div_done) begin
				env_div <= regs.env.env_period;
				if (regs.env.env_up && (volume != 4'hf)) begin
					volume <= volume + 4'd1;
				end else if (!regs.env.env_up && (volume != 4'h0)) begin
					volume <= volume - 4'd1;
				end
			end else begin
				env_div <= env_div - 3'd1;
			end
		end
	end

	// channel active flag
	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
		end else if (ctrl.trigger) begin
			active <= dac_en;
		end else if (ctrl.dac_off_write || len_expire) begin
			active <= 1'b0;
		end
	end

	assign ch2_active = active;

	// amplitude, volume gated by wave bit
	always_ff @(posedge amuk_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			ch2_out <= '0;
		end else begin
			ch2_out <= volume & {4{active && wave_hi}};
		end
	end

endmodule

`default_nettype wire

// ==== hw/apu_ch2_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module apu_ch2_top #(
	parameter int FS_DIV = 8192
) (
	input  logic       amuk_4mhz,
	input  logic       rst_n,
	input  logic       wr_en,
	input  logic [7:0] wr_addr,
	input  logic [7:0] wr_data,
	output logic [3:0] ch2_out,
	output logic       ch2_active,
	output logic       dac_en
);
	import apu_reg_pkg::*;
	import apu_timing_pkg::*;

	ch2_regs_t regs;
	ch2_ctrl_t ctrl;
	fs_tick_t  ticks;

	apu_ch2_regs apu_ch2_regs_i (
		.amuk_4mhz (amuk_4mhz),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.regs      (regs),
		.ctrl      (ctrl)
	);

	frame_sequencer #(
		.FS_DIV (FS_DIV)
	) frame_sequencer_i (
		.amuk_4mhz (amuk_4mhz),
		.rst_n     (rst_n),
		.ticks     (ticks)
	);

	pulse_channel pulse_channel_i (
		.amuk_4mhz  (amuk_4mhz),
		.rst_n      (rst_n),
		.regs       (regs),
		.ctrl       (ctrl),
		.ticks      (ticks),
		.ch2_out    (ch2_out),
		.ch2_active (ch2_active),
		.dac_en     (dac_en)
	);

endmodule

`default_nettype wire

// ==== verif/tb_apu_ch2_model.svh ====
`ifndef TB_APU_CH2_MODEL_SVH
`define TB_APU_CH2_MODEL_SVH

typedef struct packed {
	logic [1:0]  duty;
	logic [5:0]  length_init;
	logic [3:0]  init_vol;
	logic        env_up;
	logic [2:0]  env_period;
	logic [10:0] freq;
	logic        length_en;
	logic        trig_p; // strobes from the register block
	logic        load_p;
	logic        dac_off_p;
	logic [15:0] div;
	logic [2:0]  step;
	logic        len_tick;
	logic        env_tick;
	logic [12:0] timer;
	logic [2:0]  pos;
	logic [6:0]  len;
	logic [2:0]  env_cnt;
	logic [3:0]  vol;
	logic        active;
	logic        dac; // expected dac_en
	logic [3:0]  out; // expected ch2_out
} model_t;

// one clock edge of the whole channel
function automatic model_t model_step(input model_t s, input logic en,
	input logic [7:0] addr, input logic [7:0] data);
	model_t n;
	logic   wrap;
	logic   hi;
	logic   dac;
	logic   dec;
	logic   expire;
	int     per;
	n = s;
	n.trig_p    = en && (addr == ADDR_NR24) && data[7];
	n.load_p    = en && (addr == ADDR_NR21);
	n.dac_off_p = en && (addr == ADDR_NR22) && (data[7:3] == 5'd0);
	if (en && (addr == ADDR_NR21)) begin
		{n.duty, n.length_init} = data;
	end
	if (en && (addr == ADDR_NR22)) begin
		{n.init_vol, n.env_up, n.env_period} = data;
	end
	if (en && (addr == ADDR_NR23)) begin
		n.freq[7:0] = data;
	end
	if (en && (addr == ADDR_NR24)) begin
		n.freq[10:8] = data[2:0];
		n.length_en  = data[6];
	end
	wrap       = (s.div == 16'(FS_DIV - 1));
	n.div      = wrap ? 16'd0 : s.div + 16'd1;
	n.len_tick = wrap && !s.step[0];
	n.env_tick = wrap && (s.step == 3'(FS_STEPS - 1));
	if (wrap) begin
		n.step = s.step + 3'd1;
	end
	case (s.duty)
		2'd0:    hi = (s.pos == 3'd7);
		2'd1:    hi = (s.pos == 3'd0) || (s.pos == 3'd7);
		2'd2:    hi = (s.pos == 3'd0) || (s.pos >= 3'd5);
		default: hi = (s.pos >= 3'd1) && (s.pos <= 3'd6);
	endcase
	n.out = (s.active && hi) ? s.vol : 4'd0;
	per   = (2048 - int'(s.freq)) * TIMER_SCALE; // T-cycles per duty step
	if (s.trig_p || (s.timer == 13'd0)) begin
		n.timer = 13'(per - 1);
		n.pos   = s.trig_p ? 3'd0 : s.pos + 3'd1;
	end else begin
		n.timer = s.timer - 13'd1;
	end
	dec    = s.len_tick && s.length_en && (s.len != 7'd0);
	expire = dec && (s.len == 7'd1);
	if (s.trig_p) begin
		if (s.len == 7'd0) begin
			n.len = 7'(LEN_MAX);
		end
	end else if (s.load_p) begin
		n.len = 7'(LEN_MAX) - {1'b0, s.length_init};
	end else if (dec) begin
		n.len = s.len - 7'd1;
	end
	if (s.trig_p) begin
		n.env_cnt = s.env_period;
		n.vol     = s.init_vol;
	end else if (s.env_tick && (s.env_period != 3'd0)) begin
		if (s.env_cnt > 3'd1) begin
			n.env_cnt = s.env_cnt - 3'd1;
		end else begin
			n.env_cnt = s.env_period;
			if (s.env_up && (s.vol != 4'hf)) begin
				n.vol = s.vol + 4'd1;
			end else if (!s.env_up && (s.vol != 4'h0)) begin
				n.vol = s.vol - 4'd1;
			end
		end
	end
	dac = (s.init_vol != 4'd0) || s.env_up;
	if (s.trig_p) begin
		n.active = dac;
	end else if (s.dac_off_p || expire) begin
		n.active = 1'b0;
	end
	n.dac = (n.init_vol != 4'd0) || n.env_up;
	return n;
endfunction

task automatic check_value(input string name, input logic [15:0] got,
	input logic [15:0] exp);
	if (got !== exp) begin
		$display("ERROR: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		$display("Test failed");
		$fatal(1, "mismatch on %s", name);
	end
endtask

`endif

// ==== verif/tb_apu_ch2.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_apu_ch2;
	import apu_reg_pkg::*;
	import apu_timing_pkg::*;

	localparam int FS_DIV     = 64;
	localparam int CLK_PERIOD = 20;
	localparam int DUTY_FREQ  = 2040;
	localparam int DUTY_WAIT  = 8 * (2048 - DUTY_FREQ) * TIMER_SCALE + 8; // eight periods
	localparam int LEN_WAIT   = 5 * 2 * FS_DIV; // five len_tick spacings
	localparam int LEN_FULL   = (LEN_MAX + 1) * 2 * FS_DIV; // past a full length count
	localparam int ENV_SPAN   = FS_STEPS * FS_DIV;
	localparam int ENV_TICKS  = 20; // sum over the envelope cases
	localparam int N_RAND     = 300;
	localparam int MAX_GAP    = 40;
	localparam int TEST_CYCLES = 3 + 4 * (8 + DUTY_WAIT) + 4 * (8 + LEN_WAIT) + LEN_FULL + 40
		+ 5 * 8 + ENV_TICKS * ENV_SPAN + N_RAND * (2 + MAX_GAP);
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1000;

	logic       amuk_4mhz;
	logic       rst_n;
	logic       wr_en;
	logic [7:0] wr_addr;
	logic [7:0] wr_data;
	logic [3:0] ch2_out;
	logic       ch2_active;
	logic       dac_en;

	`include "tb_apu_ch2_model.svh"

	model_t model;

	apu_ch2_top #(
		.FS_DIV (FS_DIV)
	) apu_ch2_top_i (
		.amuk_4mhz  (amuk_4mhz),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.ch2_out    (ch2_out),
		.ch2_active (ch2_active),
		.dac_en     (dac_en)
	);

	initial begin
		amuk_4mhz = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) amuk_4mhz = ~amuk_4mhz;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge amuk_4mhz);
		#1;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		@(posedge amuk_4mhz);
		#2;
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(posedge amuk_4mhz);
		#2;
		wr_en = 1'b0;
	endtask

	task automatic run_env_case(input logic [3:0] vol, input logic up,
		input logic [2:0] period, input int ticks);
		write_reg(ADDR_NR22, {vol, up, period});
		write_reg(ADDR_NR24, 8'h87);
		wait_cycles(ticks * ENV_SPAN);
	endtask

	// model runs alongside and every output is compared
	initial begin
		model = '0;
		forever begin
			@(posedge amuk_4mhz);
			if (!rst_n) begin
				model = '0;
			end else begin
				model = model_step(model, wr_en, wr_addr, wr_data);
			end
			#1;
			check_value("ch2_out", 16'(ch2_out), 16'(model.out));
			check_value("ch2_active", 16'(ch2_active), 16'(model.active));
			check_value("dac_en", 16'(dac_en), 16'(model.dac));
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, stimulus did not complete", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] rnd;
		rst_n   = 1'b0;
		wr_en   = 1'b0;
		wr_addr = 8'h00;
		wr_data = 8'h00;
		void'($urandom(32'had6a_1ed9));
		repeat (3) @(posedge amuk_4mhz);
		#2;
		rst_n = 1'b1;

		for (int d = 0; d < 4; d++) begin
			write_reg(ADDR_NR21, {2'(d), 6'd0});
			write_reg(ADDR_NR22, 8'hf0);
			write_reg(ADDR_NR23, 8'(DUTY_FREQ));
			write_reg(ADDR_NR24, 8'h80 | 8'(DUTY_FREQ >> 8));
			wait_cycles(DUTY_WAIT);
		end

		write_reg(ADDR_NR21, 8'h80 | 8'd60); // four ticks left
		write_reg(ADDR_NR24, 8'hc7);
		wait_cycles(LEN_WAIT);
		check_value("ch2_active", 16'(ch2_active), 16'h0);
		write_reg(ADDR_NR21, 8'h80 | 8'd60);
		write_reg(ADDR_NR24, 8'h87); // length_en clear
		wait_cycles(LEN_WAIT);
		check_value("ch2_active", 16'(ch2_active), 16'h1);

		write_reg(ADDR_NR22, 8'h00); // DAC off
		wait_cycles(4);
		check_value("ch2_active", 16'(ch2_active), 16'h0);
		check_value("dac_en", 16'(dac_en), 16'h0);
		check_value("ch2_out", 16'(ch2_out), 16'h0);
		write_reg(ADDR_NR24, 8'h87);
		wait_cycles(4);
		check_value("ch2_active", 16'(ch2_active), 16'h0);
		write_reg(ADDR_NR22, 8'ha0);
		write_reg(ADDR_NR24, 8'h87);
		wait_cycles(4);
		check_value("dac_en", 16'(dac_en), 16'h1);
		check_value("ch2_active", 16'(ch2_active), 16'h1);

		write_reg(ADDR_NR21, 8'h80);
		run_env_case(4'd2, 1'b0, 3'd1, 4);
		run_env_case(4'd13, 1'b1, 3'd1, 4);
		run_env_case(4'd1, 1'b0, 3'd3, 5);
		run_env_case(4'd14, 1'b1, 3'd3, 5);
		run_env_case(4'd7, 1'b0, 3'd0, 2); // envelope off

		write_reg(ADDR_NR21, 8'hbf); // one tick left
		write_reg(ADDR_NR24, 8'hc7);
		wait_cycles(LEN_WAIT);
		check_value("ch2_active", 16'(ch2_active), 16'h0);
		write_reg(ADDR_NR24, 8'hc7); // zero count reloads to 64
		wait_cycles(LEN_WAIT);
		check_value("ch2_active", 16'(ch2_active), 16'h1);
		wait_cycles(LEN_FULL - LEN_WAIT);
		check_value("ch2_active", 16'(ch2_active), 16'h0);

		for (int i = 0; i < N_RAND; i++) begin
			rnd = $urandom;
			case (rnd[9:8])
				2'd0:    write_reg(ADDR_NR21, rnd[7:0]);
				2'd1:    write_reg(ADDR_NR22, rnd[7:0]);
				2'd2:    write_reg(ADDR_NR23, rnd[7:0]);
				default: write_reg(ADDR_NR24, {rnd[7], rnd[6] & rnd[5], 6'b000111});
			endcase
			wait_cycles(int'($urandom_range(MAX_GAP, 1)));
		end

		wait_cycles(4);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== apu_ch2_top.f ====
+incdir+verif
hw/apu_reg_pkg.sv
hw/apu_timing_pkg.sv
hw/apu_ch2_regs.sv
hw/frame_sequencer.sv
hw/pulse_channel.sv
hw/apu_ch2_top.sv
verif/tb_apu_ch2.sv

// ==== Makefile ====
TOP := tb_apu_ch2

.PHONY: all compile run clean

all: run

compile: obj_dir/sim

obj_dir/sim: apu_ch2_top.f hw/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --top-module $(TOP) -f apu_ch2_top.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee run.log
	@if grep -q "^Test passed$$" run.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir run.log
